/* compile.f */
+incdir+design
design/tl_chan_pkg.sv
design/tl_map_pkg.sv
design/tl_addr_decode.sv
design/tl_req_arbiter.sv
design/tl_a_buffer.sv
design/tl_resp_router.sv
design/tl_xbar.sv
testbench/tb_tl_xbar.sv

/* Makefile */
# Verilator build and run for the TileLink crossbar testbench

VERILATOR  ?= verilator
TOP        ?= tb_tl_xbar
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   ?= Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || \
		(echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/tb_tl_xbar.sv */
// Testbench for the two-by-two TileLink crossbar
// Queue-driven masters, slave models that answer each request,
// directed tests for routing, arbitration, back-pressure and responses
`timescale 1ns/1ps
`default_nettype none

`include "tl_defs.svh"

module tb_tl_xbar;
    import tl_chan_pkg::*;
    import tl_map_pkg::*;

    localparam int M            = `TL_MASTER_NUM;
    localparam int S            = `TL_SLAVE_NUM;
    localparam int RESET_CYCLES = 5;
    localparam int ROUTE_REQS   = 10;
    localparam int RR_REQS      = 6;
    localparam int STALL_REQS   = 4;
    localparam int RESP_REQS    = 3;
    // About 40 cycles per request covers random ready and draining
    localparam int MAX_CYCLES   = RESET_CYCLES + 100 +
                                  40 * (ROUTE_REQS + M * RR_REQS + STALL_REQS + RESP_REQS);

    localparam tl_opcode_t OP_GET      = 3'd4;
    localparam tl_opcode_t OP_ACK_DATA = 3'd1;

    // Ready behaviour of a model port
    localparam logic [1:0] RDY_LOW  = 2'd0;
    localparam logic [1:0] RDY_RAND = 2'd1;
    localparam logic [1:0] RDY_HIGH = 2'd2;

    logic               clk;
    logic               rst;
    logic [M-1:0]       m_a_valid;
    logic [M-1:0]       m_a_ready;
    tl_a_chan_t [M-1:0] m_a_bits;
    logic [M-1:0]       m_d_valid;
    logic [M-1:0]       m_d_ready;
    tl_d_chan_t [M-1:0] m_d_bits;
    logic [S-1:0]       s_a_valid;
    logic [S-1:0]       s_a_ready;
    tl_a_chan_t [S-1:0] s_a_bits;
    logic [S-1:0]       s_d_valid;
    logic [S-1:0]       s_d_ready;
    tl_d_chan_t [S-1:0] s_d_bits;
    tl_region_t [S-1:0] region_map;

    // Model queues: pending at masters, seen at slaves, pending D, seen at masters
    tl_a_chan_t  m_pend [M][$];
    tl_a_chan_t  a_seen [S][$];
    tl_d_chan_t  d_pend [S][$];
    tl_d_chan_t  d_seen [M][$];
    logic [1:0]  s_rdy_mode [S];
    logic [1:0]  m_rdy_mode [M];
    logic [31:0] lcg_state;
    int          cycle_cnt = 0;

    tl_xbar dut (
        .clk_i        (clk),
        .rst_i        (rst),
        .m_a_valid_i  (m_a_valid),
        .m_a_ready_o  (m_a_ready),
        .m_a_bits_i   (m_a_bits),
        .m_d_valid_o  (m_d_valid),
        .m_d_ready_i  (m_d_ready),
        .m_d_bits_o   (m_d_bits),
        .s_a_valid_o  (s_a_valid),
        .s_a_ready_i  (s_a_ready),
        .s_a_bits_o   (s_a_bits),
        .s_d_valid_i  (s_d_valid),
        .s_d_ready_o  (s_d_ready),
        .s_d_bits_i   (s_d_bits),
        .region_map_i (region_map)
    );

    always #5 clk = ~clk;

    // ----------------------------------------
    // Helpers and compare tasks
    // ----------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic ready_from_mode(input logic [1:0] mode);
        logic [31:0] r;
        if (mode == RDY_RAND) begin
            r = lcg_next();
            return r[16];
        end
        return (mode == RDY_HIGH);
    endfunction

    function automatic tl_a_chan_t make_req(input int m, input int tag, input tl_addr_t addr);
        tl_a_chan_t r;
        r.opcode  = OP_GET;
        r.source  = (tl_source_t'(m) << `TL_SRC_MID_LSB) |
                    tl_source_t'(tag % (1 << `TL_SRC_MID_LSB));
        r.address = addr;
        r.mask    = '1;
        r.data    = 32'hc0de_0000 + tl_data_t'(tag);
        return r;
    endfunction

    // Slave answer: same source, address XOR slave index
    function automatic tl_d_chan_t slave_reply(input tl_a_chan_t req, input int s);
        tl_d_chan_t d;
        d.opcode = OP_ACK_DATA;
        d.source = req.source;
        d.data   = req.address ^ tl_data_t'(s);
        return d;
    endfunction

    // Lowest enabled region holding the address, last slave otherwise
    function automatic int ref_slave(input tl_addr_t addr);
        for (int s = 0; s < S; s++) begin
            if (region_map[s].en && addr >= region_map[s].start_addr &&
                addr <= region_map[s].end_addr) begin
                return s;
            end
        end
        return S - 1;
    endfunction

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic require(input logic cond, input string what);
        if (!cond) begin
            $display("%s", what);
            abort_run();
        end
    endtask

    task automatic check_a_chan(input string name, input tl_a_chan_t got, input tl_a_chan_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_d_chan(input string name, input tl_d_chan_t got, input tl_d_chan_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_slave_sel(input string name, input tl_slave_sel_t got,
                                   input tl_slave_sel_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_master_sel(input string name, input tl_master_sel_t got,
                                    input tl_master_sel_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic clear_seen();
        for (int s = 0; s < S; s++) begin
            a_seen[s].delete();
        end
        for (int m = 0; m < M; m++) begin
            d_seen[m].delete();
        end
    endtask

    // Region map is a DUT input, so it changes just after the edge
    task automatic set_region_en(input int s, input logic en);
        @(posedge clk);
        #1;
        region_map[s].en = en;
        @(negedge clk);
    endtask

    // Until every queue and every valid has drained
    task automatic wait_idle();
        logic busy;
        busy = 1'b1;
        while (busy) begin
            @(negedge clk);
            busy = (s_a_valid != '0) || (m_d_valid != '0);
            for (int m = 0; m < M; m++) begin
                busy = busy || (m_pend[m].size() > 0);
            end
            for (int s = 0; s < S; s++) begin
                busy = busy || (d_pend[s].size() > 0);
            end
        end
    endtask

    // ----------------------------------------
    // Master and slave models
    // ----------------------------------------
    initial begin : model_step
        logic [M-1:0] ma_hs;
        logic [M-1:0] md_hs;
        logic [S-1:0] sa_hs;
        logic [S-1:0] sd_hs;
        m_a_valid = '0;
        m_a_bits  = '0;
        m_d_ready = '0;
        s_a_ready = '0;
        s_d_valid = '0;
        s_d_bits  = '0;
        forever begin
            @(posedge clk);
            ma_hs = m_a_valid & m_a_ready;
            md_hs = m_d_valid & m_d_ready;
            sa_hs = s_a_valid & s_a_ready;
            sd_hs = s_d_valid & s_d_ready;
            for (int s = 0; s < S; s++) begin
                if (sa_hs[s]) begin
                    a_seen[s].push_back(s_a_bits[s]);
                    d_pend[s].push_back(slave_reply(s_a_bits[s], s));
                end
            end
            for (int m = 0; m < M; m++) begin
                if (md_hs[m]) begin
                    d_seen[m].push_back(m_d_bits[m]);
                end
            end
            #1;
            for (int m = 0; m < M; m++) begin
                if (ma_hs[m]) begin
                    void'(m_pend[m].pop_front());
                end
                m_a_valid[m] = (m_pend[m].size() > 0);
                m_a_bits[m]  = (m_pend[m].size() > 0) ? m_pend[m][0] : '0;
                m_d_ready[m] = ready_from_mode(m_rdy_mode[m]);
            end
            for (int s = 0; s < S; s++) begin
                if (sd_hs[s]) begin
                    void'(d_pend[s].pop_front());
                end
                s_d_valid[s] = (d_pend[s].size() > 0);
                s_d_bits[s]  = (d_pend[s].size() > 0) ? d_pend[s][0] : '0;
                s_a_ready[s] = ready_from_mode(s_rdy_mode[s]);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_reset();
        @(negedge clk);
        check_slave_sel("s_a_valid", s_a_valid, '0);
        check_master_sel("m_d_valid", m_d_valid, '0);
    endtask

    // One request, then its slave, payload and D response
    task automatic route_one(input int m, input int tag, input tl_addr_t addr);
        tl_a_chan_t    req;
        tl_a_chan_t    got_a;
        tl_slave_sel_t got_sel;
        int            exp_s;
        req     = make_req(m, tag, addr);
        exp_s   = ref_slave(addr);
        got_a   = '0;
        got_sel = '0;
        clear_seen();
        m_pend[m].push_back(req);
        while (a_seen[0].size() + a_seen[1].size() == 0) @(negedge clk);
        for (int s = 0; s < S; s++) begin
            if (a_seen[s].size() > 0) begin
                got_sel[s] = 1'b1;
                got_a      = a_seen[s][0];
            end
        end
        check_slave_sel("slave select", got_sel, tl_slave_sel_t'(1 << exp_s));
        check_a_chan("s_a_bits", got_a, req);
        while (d_seen[m].size() == 0) @(negedge clk);
        check_d_chan("m_d_bits", d_seen[m][0], slave_reply(req, exp_s));
    endtask

    task automatic test_routing();
        tl_addr_t addrs [8];
        addrs = '{32'h1000_0000, 32'h1fff_fffc, 32'h2000_0000, 32'h2abc_0010,
                  32'h0000_0040, 32'hf000_0000, 32'h1234_5678, 32'h2fff_fffc};
        for (int i = 0; i < S; i++) begin
            s_rdy_mode[i] = RDY_HIGH;
        end
        for (int i = 0; i < M; i++) begin
            m_rdy_mode[i] = RDY_HIGH;
        end
        for (int i = 0; i < 8; i++) begin
            route_one(i % M, i, addrs[i]);
        end
        // Disabled region falls through to the default slave
        set_region_en(0, 1'b0);
        route_one(0, 8, 32'h1000_0100);
        route_one(1, 9, 32'h1800_0000);
        set_region_en(0, 1'b1);
    endtask

    task automatic test_round_robin();
        tl_a_chan_t sent [M][$];
        tl_a_chan_t req;
        tl_a_chan_t got;
        int         idx [M];
        int         mid;
        int         prev_mid;
        s_rdy_mode[0] = RDY_RAND;
        clear_seen();
        for (int i = 0; i < RR_REQS; i++) begin
            for (int m = 0; m < M; m++) begin
                req = make_req(m, i, 32'h1000_1000 + tl_addr_t'(16 * i + 4 * m));
                sent[m].push_back(req);
                m_pend[m].push_back(req);
            end
        end
        while (a_seen[0].size() < M * RR_REQS) @(negedge clk);
        wait_idle();
        require(a_seen[0].size() == M * RR_REQS && a_seen[1].size() == 0,
                "Requests were lost, duplicated or misrouted under contention");
        for (int m = 0; m < M; m++) begin
            idx[m] = 0;
        end
        prev_mid = -1;
        for (int k = 0; k < M * RR_REQS; k++) begin
            got = a_seen[0][k];
            mid = int'(got.source[`TL_SRC_MID_MSB:`TL_SRC_MID_LSB]);
            require(mid != prev_mid, "The same master won slave 0 twice in a row");
            check_a_chan("s_a_bits[0]", got, sent[mid][idx[mid]]);
            idx[mid]++;
            prev_mid = mid;
        end
    endtask

    task automatic test_backpressure();
        tl_a_chan_t reqs [$];
        tl_a_chan_t req;
        s_rdy_mode[1] = RDY_LOW;
        clear_seen();
        for (int i = 0; i < STALL_REQS; i++) begin
            req = make_req(0, i, 32'h2000_0100 + tl_addr_t'(4 * i));
            reqs.push_back(req);
            m_pend[0].push_back(req);
        end
        // Buffer takes two, then the master stalls
        while (m_pend[0].size() > STALL_REQS - 2) @(negedge clk);
        repeat (4) begin
            @(negedge clk);
            check_slave_sel("s_a_valid", s_a_valid, tl_slave_sel_t'(1 << (S - 1)));
            check_a_chan("s_a_bits[1]", s_a_bits[1], reqs[0]);
            check_master_sel("m_a_ready", m_a_ready, '0);
            require(m_pend[0].size() == STALL_REQS - 2,
                    "Master 0 got a request past a full buffer");
        end
        s_rdy_mode[1] = RDY_RAND;
        while (a_seen[1].size() < STALL_REQS) @(negedge clk);
        wait_idle();
        require(a_seen[1].size() == STALL_REQS && a_seen[0].size() == 0,
                "Stalled requests were lost or duplicated after release");
        for (int i = 0; i < STALL_REQS; i++) begin
            check_a_chan("s_a_bits[1]", a_seen[1][i], reqs[i]);
        end
    endtask

    task automatic test_responses();
        tl_a_chan_t r0;
        tl_a_chan_t r1;
        tl_a_chan_t r2;
        tl_d_chan_t got;
        for (int i = 0; i < S; i++) begin
            s_rdy_mode[i] = RDY_HIGH;
        end
        m_rdy_mode[0] = RDY_LOW;
        clear_seen();
        r0 = make_req(0, 1, 32'h1000_0200);
        r1 = make_req(0, 2, 32'h2000_0200);
        m_pend[0].push_back(r0);
        m_pend[0].push_back(r1);
        // Both slaves answering master 0 at once
        while (s_d_valid != '1) @(negedge clk);
        repeat (3) begin
            @(negedge clk);
            check_slave_sel("s_d_ready", s_d_ready, '0);
            check_master_sel("m_d_valid", m_d_valid, tl_master_sel_t'(1));
        end
        m_rdy_mode[0] = RDY_HIGH;
        while (d_seen[0].size() < 2) @(negedge clk);
        require(d_seen[0][0].source != d_seen[0][1].source,
                "Master 0 received one response twice");
        // Arrival order follows the router pointer
        for (int k = 0; k < 2; k++) begin
            got = d_seen[0][k];
            if (got.source == r0.source) begin
                check_d_chan("m_d_bits[0]", got, slave_reply(r0, 0));
            end else begin
                check_d_chan("m_d_bits[0]", got, slave_reply(r1, 1));
            end
        end
        r2 = make_req(1, 3, 32'h1000_0300);
        m_pend[1].push_back(r2);
        while (d_seen[1].size() == 0) @(negedge clk);
        wait_idle();
        check_d_chan("m_d_bits[1]", d_seen[1][0], slave_reply(r2, 0));
        require(d_seen[0].size() == 2 && d_seen[1].size() == 1,
                "A response reached the wrong master");
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin : main
        clk       = 1'b0;
        rst       = 1'b1;
        lcg_state = 32'hda0e849d;
        for (int i = 0; i < S; i++) begin
            s_rdy_mode[i] = RDY_LOW;
        end
        for (int i = 0; i < M; i++) begin
            m_rdy_mode[i] = RDY_LOW;
        end
        region_map[0].start_addr = 32'h1000_0000;
        region_map[0].end_addr   = 32'h1fff_ffff;
        region_map[0].en         = 1'b1;
        region_map[1].start_addr = 32'h2000_0000;
        region_map[1].end_addr   = 32'h2fff_ffff;
        region_map[1].en         = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset();
        test_routing();
        test_round_robin();
        test_backpressure();
        test_responses();
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* design/tl_xbar.sv */
// Two-by-two TileLink crossbar, A and D channels
// Decode, arbitrate and buffer requests per slave, route responses per master
`timescale 1ns/1ps
`default_nettype none

`include "tl_defs.svh"

module tl_xbar (
    input  logic                                         clk_i,
    input  logic                                         rst_i,
    input  logic [`TL_MASTER_NUM-1:0]                    m_a_valid_i,
    output logic [`TL_MASTER_NUM-1:0]                    m_a_ready_o,
    input  tl_chan_pkg::tl_a_chan_t [`TL_MASTER_NUM-1:0] m_a_bits_i,
    output logic [`TL_MASTER_NUM-1:0]                    m_d_valid_o,
    input  logic [`TL_MASTER_NUM-1:0]                    m_d_ready_i,
    output tl_chan_pkg::tl_d_chan_t [`TL_MASTER_NUM-1:0] m_d_bits_o,
    output logic [`TL_SLAVE_NUM-1:0]                     s_a_valid_o,
    input  logic [`TL_SLAVE_NUM-1:0]                     s_a_ready_i,
    output tl_chan_pkg::tl_a_chan_t [`TL_SLAVE_NUM-1:0]  s_a_bits_o,
    input  logic [`TL_SLAVE_NUM-1:0]                     s_d_valid_i,
    output logic [`TL_SLAVE_NUM-1:0]                     s_d_ready_o,
    input  tl_chan_pkg::tl_d_chan_t [`TL_SLAVE_NUM-1:0]  s_d_bits_i,
    input  tl_map_pkg::tl_region_t [`TL_SLAVE_NUM-1:0]   region_map_i
);
    import tl_chan_pkg::*;
    import tl_map_pkg::*;

    // Request and ready matrices, both orientations
    tl_slave_sel_t  [`TL_MASTER_NUM-1:0] a_sel;
    tl_slave_sel_t  [`TL_MASTER_NUM-1:0] a_req_ms;
    tl_master_sel_t [`TL_SLAVE_NUM-1:0]  a_req_sm;
    tl_master_sel_t [`TL_SLAVE_NUM-1:0]  a_rdy_sm;
    tl_slave_sel_t  [`TL_MASTER_NUM-1:0] a_rdy_ms;
    tl_slave_sel_t  [`TL_MASTER_NUM-1:0] d_rdy_ms;

    logic       [`TL_SLAVE_NUM-1:0] push;
    logic       [`TL_SLAVE_NUM-1:0] full;
    tl_a_chan_t [`TL_SLAVE_NUM-1:0] push_bits;

    // ----------------------------------------
    // Request path
    // ----------------------------------------
    for (genvar m = 0; m < `TL_MASTER_NUM; m++) begin : g_master_a
        tl_addr_decode u_decode (
            .addr_i       (m_a_bits_i[m].address),
            .region_map_i (region_map_i),
            .slave_sel_o  (a_sel[m])
        );
        assign a_req_ms[m]    = a_sel[m] & {`TL_SLAVE_NUM{m_a_valid_i[m]}};
        assign m_a_ready_o[m] = |a_rdy_ms[m];
    end

    for (genvar s = 0; s < `TL_SLAVE_NUM; s++) begin : g_transpose_s
        for (genvar m = 0; m < `TL_MASTER_NUM; m++) begin : g_transpose_m
            assign a_req_sm[s][m] = a_req_ms[m][s];
            assign a_rdy_ms[m][s] = a_rdy_sm[s][m];
        end
    end

    for (genvar s = 0; s < `TL_SLAVE_NUM; s++) begin : g_slave_a
        tl_req_arbiter u_arb (
            .clk_i       (clk_i),
            .rst_i       (rst_i),
            .req_i       (a_req_sm[s]),
            .a_bits_i    (m_a_bits_i),
            .ready_o     (a_rdy_sm[s]),
            .push_o      (push[s]),
            .push_bits_o (push_bits[s]),
            .full_i      (full[s])
        );

        tl_a_buffer u_buf (
            .clk_i       (clk_i),
            .rst_i       (rst_i),
            .push_i      (push[s]),
            .push_bits_i (push_bits[s]),
            .full_o      (full[s]),
            .a_valid_o   (s_a_valid_o[s]),
            .a_ready_i   (s_a_ready_i[s]),
            .a_bits_o    (s_a_bits_o[s])
        );
    end

    // ----------------------------------------
    // Response path
    // ----------------------------------------
    for (genvar m = 0; m < `TL_MASTER_NUM; m++) begin : g_master_d
        tl_resp_router #(
            .MASTER_IDX (m)
        ) u_router (
            .clk_i     (clk_i),
            .rst_i     (rst_i),
            .d_valid_i (s_d_valid_i),
            .d_bits_i  (s_d_bits_i),
            .d_ready_o (d_rdy_ms[m]),
            .d_valid_o (m_d_valid_o[m]),
            .d_ready_i (m_d_ready_i[m]),
            .d_bits_o  (m_d_bits_o[m])
        );
    end

    // Only one router can claim a response
    always_comb begin
        s_d_ready_o = '0;
        for (int m = 0; m < `TL_MASTER_NUM; m++) begin
            s_d_ready_o = s_d_ready_o | d_rdy_ms[m];
        end
    end

endmodule

`default_nettype wire

/* design/tl_resp_router.sv */
// D channel router for one master
// Claims responses by source master id, round-robin over slaves
`timescale 1ns/1ps
`default_nettype none

`include "tl_defs.svh"

module tl_resp_router #(
    parameter int MASTER_IDX = 0
) (
    input  logic                                        clk_i,
    input  logic                                        rst_i,
    input  tl_map_pkg::tl_slave_sel_t                   d_valid_i,
    input  tl_chan_pkg::tl_d_chan_t [`TL_SLAVE_NUM-1:0] d_bits_i,
    output tl_map_pkg::tl_slave_sel_t                   d_ready_o,
    output logic                                        d_valid_o,
    input  logic                                        d_ready_i,
    output tl_chan_pkg::tl_d_chan_t                     d_bits_o
);
    import tl_map_pkg::*;

    localparam int MID_W = `TL_SRC_MID_MSB - `TL_SRC_MID_LSB + 1;
    localparam int IDX_W = (`TL_SLAVE_NUM > 1) ? $clog2(`TL_SLAVE_NUM) : 1;

    typedef logic [MID_W-1:0] mid_t;
    typedef logic [IDX_W-1:0] slv_idx_t;
    typedef enum logic {RSP_OPEN, RSP_HOLD} rsp_state_e;

    localparam mid_t MY_ID = mid_t'(MASTER_IDX);

    rsp_state_e    state_q;
    slv_idx_t      ptr_q;
    slv_idx_t      hold_idx_q;
    tl_slave_sel_t claim;
    slv_idx_t      gnt_idx;
    logic          gnt_vld;

    // Responses addressed to this master
    always_comb begin
        for (int s = 0; s < `TL_SLAVE_NUM; s++) begin
            claim[s] = d_valid_i[s] &&
                       (d_bits_i[s].source[`TL_SRC_MID_MSB:`TL_SRC_MID_LSB] == MY_ID);
        end
    end

    // Held choice first, otherwise rotate from the pointer
    always_comb begin
        gnt_idx = ptr_q;
        gnt_vld = 1'b0;
        if (state_q == RSP_HOLD) begin
            gnt_idx = hold_idx_q;
            gnt_vld = claim[hold_idx_q];
        end else begin
            for (int k = `TL_SLAVE_NUM-1; k >= 0; k--) begin
                if (claim[(int'(ptr_q) + k) % `TL_SLAVE_NUM]) begin
                    gnt_idx = slv_idx_t'((int'(ptr_q) + k) % `TL_SLAVE_NUM);
                    gnt_vld = 1'b1;
                end
            end
        end
    end

    assign d_valid_o = gnt_vld;
    assign d_bits_o  = d_bits_i[gnt_idx];

    always_comb begin
        d_ready_o = '0;
        d_ready_o[gnt_idx] = gnt_vld && d_ready_i;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= RSP_OPEN;
            ptr_q      <= '0;
            hold_idx_q <= '0;
        end else begin
            if (gnt_vld && d_ready_i) begin
                state_q <= RSP_OPEN;
                ptr_q   <= slv_idx_t'((int'(gnt_idx) + 1) % `TL_SLAVE_NUM);
            end else if (gnt_vld) begin
                // Master stalled, keep this slave
                state_q    <= RSP_HOLD;
                hold_idx_q <= gnt_idx;
            end
        end
    end

endmodule

`default_nettype wire

/* design/tl_a_buffer.sv */
// Request buffer for one slave port
// Small registered FIFO, head entry drives the slave A channel
`timescale 1ns/1ps
`default_nettype none

`include "tl_defs.svh"

module tl_a_buffer (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    push_i,
    input  tl_chan_pkg::tl_a_chan_t push_bits_i,
    output logic                    full_o,
    output logic                    a_valid_o,
    input  logic                    a_ready_i,
    output tl_chan_pkg::tl_a_chan_t a_bits_o
);
    import tl_chan_pkg::*;

    localparam int DEPTH = `TL_BUF_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    typedef logic [PTR_W-1:0] buf_ptr_t;
    typedef logic [PTR_W:0]   buf_cnt_t;

    tl_a_chan_t mem_q [DEPTH];
    buf_ptr_t   wr_ptr_q;
    buf_ptr_t   rd_ptr_q;
    buf_cnt_t   cnt_q;
    logic       do_push;
    logic       do_pop;

    function automatic buf_ptr_t ptr_inc(input buf_ptr_t ptr);
        return (ptr == buf_ptr_t'(DEPTH-1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full_o    = (cnt_q == buf_cnt_t'(DEPTH));
    assign a_valid_o = (cnt_q != '0);
    assign a_bits_o  = mem_q[rd_ptr_q];

    assign do_push = push_i && !full_o;
    assign do_pop  = a_valid_o && a_ready_i;

    // Storage
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_bits_i;
        end
    end

    // Pointers and fill level
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({do_push, do_pop})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/tl_req_arbiter.sv */
// A channel arbiter for one slave
// Round-robin among requesting masters, grant held until the push goes through
`timescale 1ns/1ps
`default_nettype none

`include "tl_defs.svh"

module tl_req_arbiter (
    input  logic                                         clk_i,
    input  logic                                         rst_i,
    input  tl_map_pkg::tl_master_sel_t                   req_i,
    input  tl_chan_pkg::tl_a_chan_t [`TL_MASTER_NUM-1:0] a_bits_i,
    output tl_map_pkg::tl_master_sel_t                   ready_o,
    output logic                                         push_o,
    output tl_chan_pkg::tl_a_chan_t                      push_bits_o,
    input  logic                                         full_i
);
    import tl_map_pkg::*;

    localparam int IDX_W = (`TL_MASTER_NUM > 1) ? $clog2(`TL_MASTER_NUM) : 1;

    typedef logic [IDX_W-1:0] mst_idx_t;
    typedef enum logic {ARB_OPEN, ARB_HOLD} arb_state_e;

    arb_state_e state_q;
    mst_idx_t   ptr_q;
    mst_idx_t   hold_idx_q;
    mst_idx_t   pick_idx;
    logic       pick_vld;
    mst_idx_t   gnt_idx;
    logic       gnt_vld;

    // ----------------------------------------
    // Grant selection
    // ----------------------------------------

    // Search starts at the pointer, nearest requester wins
    always_comb begin
        pick_idx = ptr_q;
        pick_vld = 1'b0;
        for (int k = `TL_MASTER_NUM-1; k >= 0; k--) begin
            if (req_i[(int'(ptr_q) + k) % `TL_MASTER_NUM]) begin
                pick_idx = mst_idx_t'((int'(ptr_q) + k) % `TL_MASTER_NUM);
                pick_vld = 1'b1;
            end
        end
    end

    // A held winner keeps the grant while the buffer is full
    always_comb begin
        if (state_q == ARB_HOLD) begin
            gnt_idx = hold_idx_q;
            gnt_vld = req_i[hold_idx_q];
        end else begin
            gnt_idx = pick_idx;
            gnt_vld = pick_vld;
        end
    end

    assign push_o      = gnt_vld && !full_i;
    assign push_bits_o = a_bits_i[gnt_idx];

    always_comb begin
        ready_o = '0;
        ready_o[gnt_idx] = push_o;
    end

    // ----------------------------------------
    // Lock state and pointer
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= ARB_OPEN;
            ptr_q      <= '0;
            hold_idx_q <= '0;
        end else begin
            case (state_q)
                ARB_OPEN: begin
                    if (gnt_vld && full_i) begin
                        state_q    <= ARB_HOLD;
                        hold_idx_q <= gnt_idx;
                    end
                end
                ARB_HOLD: begin
                    if (push_o) begin
                        state_q <= ARB_OPEN;
                    end
                end
                default: state_q <= ARB_OPEN;
            endcase
            // Move past the winner
            if (push_o) begin
                ptr_q <= mst_idx_t'((int'(gnt_idx) + 1) % `TL_MASTER_NUM);
            end
        end
    end

endmodule

`default_nettype wire

/* design/tl_addr_decode.sv */
// Address decoder for one master
// Matches the request address against the region map, gives a one-hot slave select
`timescale 1ns/1ps
`default_nettype none

`include "tl_defs.svh"

module tl_addr_decode (
    input  tl_chan_pkg::tl_addr_t                      addr_i,
    input  tl_map_pkg::tl_region_t [`TL_SLAVE_NUM-1:0] region_map_i,
    output tl_map_pkg::tl_slave_sel_t                  slave_sel_o
);
    import tl_map_pkg::*;

    tl_slave_sel_t hit;

    // Region compare per slave
    always_comb begin
        hit = '0;
        for (int s = 0; s < `TL_SLAVE_NUM; s++) begin
            hit[s] = region_map_i[s].en &&
                     (addr_i >= region_map_i[s].start_addr) &&
                     (addr_i <= region_map_i[s].end_addr);
        end
    end

    // Lowest index wins, last slave catches misses
    always_comb begin
        slave_sel_o = '0;
        slave_sel_o[`TL_SLAVE_NUM-1] = 1'b1;
        for (int s = `TL_SLAVE_NUM-1; s >= 0; s--) begin
            if (hit[s]) begin
                slave_sel_o    = '0;
                slave_sel_o[s] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/tl_map_pkg.sv */
// Crossbar memory map types
// One address region per slave plus the one-hot select vectors
`default_nettype none

`include "tl_defs.svh"

package tl_map_pkg;

    // End address is inclusive
    typedef struct packed {
        tl_chan_pkg::tl_addr_t start_addr;
        tl_chan_pkg::tl_addr_t end_addr;
        logic                  en;
    } tl_region_t;

    typedef logic [`TL_SLAVE_NUM-1:0]  tl_slave_sel_t;
    typedef logic [`TL_MASTER_NUM-1:0] tl_master_sel_t;

endpackage

`default_nettype wire

/* design/tl_chan_pkg.sv */
// TileLink A and D channel types
// Field vectors and the channel payload structs carried through the crossbar
`default_nettype none

`include "tl_defs.svh"

package tl_chan_pkg;

    typedef logic [`TL_ADDR_W-1:0]   tl_addr_t;
    typedef logic [`TL_DATA_W-1:0]   tl_data_t;
    typedef logic [`TL_SRC_W-1:0]    tl_source_t;
    typedef logic [2:0]              tl_opcode_t;
    typedef logic [`TL_DATA_W/8-1:0] tl_mask_t;

    // Request payload, 75 bits
    typedef struct packed {
        tl_opcode_t opcode;
        tl_source_t source;
        tl_addr_t   address;
        tl_mask_t   mask;
        tl_data_t   data;
    } tl_a_chan_t;

    // Response payload, 39 bits
    typedef struct packed {
        tl_opcode_t opcode;
        tl_source_t source;
        tl_data_t   data;
    } tl_d_chan_t;

endpackage

`default_nettype wire

/* design/tl_defs.svh */
// TileLink crossbar build constants
// Port counts, field widths and the position of the master id in the source field
`ifndef TL_DEFS_SVH
`define TL_DEFS_SVH

// Crossbar size
`define TL_MASTER_NUM 2
`define TL_SLAVE_NUM 2

// Channel field widths
`define TL_ADDR_W 32
`define TL_DATA_W 32
`define TL_SRC_W 4

// Source bits naming the issuing master
`define TL_SRC_MID_LSB 3
`define TL_SRC_MID_MSB 3

// Request buffer in front of each slave
`define TL_BUF_DEPTH 2

`endif
